/* id_pkg.sv */
package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_AND   = 8'b0010_0100,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

    // one instruction word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            reg_addr_t   rd;
            logic [4:0]  shamt;
            logic [5:0]  funct;
        } r;
        struct packed {
            logic [5:0]       opcode;
            reg_addr_t        rs;
            reg_addr_t        rt;
            logic [IMM_W-1:0] imm16;
        } i;
    } inst_u;

endpackage

/* id_if.sv */
`timescale 1ns/10ps

interface dec_if;
    import id_pkg::*;

    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     imm;
    aluop_e    aluop;
    alusel_e   alusel;
    reg_addr_t wd;
    logic      wreg;
    logic      inst_ok;

    modport dec  (output reg1_read, reg2_read, reg1_addr, reg2_addr, imm,
                  aluop, alusel, wd, wreg, inst_ok);
    modport sel  (input reg1_read, reg2_read, reg1_addr, reg2_addr, imm);
    modport pipe (input aluop, alusel, wd, wreg, inst_ok);
endinterface

interface fwd_if;
    import id_pkg::*;

    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_wreg;
    reg_addr_t mem_wd;
    word_t     mem_wdata;

    modport src (output ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata);
    modport snk (input ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata);
endinterface

/* inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  id_pkg::inst_u inst_i,
    dec_if.dec            dec
);
    import id_pkg::*;

    logic    is_special;
    logic    shift_imm;      // sll/srl/sra take shamt in place of rs
    logic    r_ok;
    logic    ok;
    aluop_e  r_op;
    aluop_e  i_op;
    aluop_e  op;
    word_t   i_imm;

    function automatic alusel_e class_of(input aluop_e a);
        case (a)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
            ALU_NOP:                           return SEL_NOP;
            default:                           return SEL_ARITH;
        endcase
    endfunction

    assign is_special = (inst_i.r.opcode == OP_SPECIAL);
    assign shift_imm  = (inst_i.r.funct == FN_SLL) ||
                        (inst_i.r.funct == FN_SRL) ||
                        (inst_i.r.funct == FN_SRA);

    always_comb
    begin
        case (inst_i.r.funct)
            FN_OR:            r_op = ALU_OR;
            FN_AND:           r_op = ALU_AND;
            FN_XOR:           r_op = ALU_XOR;
            FN_NOR:           r_op = ALU_NOR;
            FN_SLLV, FN_SLL:  r_op = ALU_SLL;
            FN_SRLV, FN_SRL:  r_op = ALU_SRL;
            FN_SRAV, FN_SRA:  r_op = ALU_SRA;
            FN_ADD:           r_op = ALU_ADD;
            FN_ADDU:          r_op = ALU_ADDU;
            FN_SUB:           r_op = ALU_SUB;
            FN_SUBU:          r_op = ALU_SUBU;
            FN_SLT:           r_op = ALU_SLT;
            FN_SLTU:          r_op = ALU_SLTU;
            default:          r_op = ALU_NOP;   // mult, hi/lo, movz etc.
        endcase
    end

    // the unused rs or shamt field must be zero
    assign r_ok = (r_op != ALU_NOP) &&
                  (shift_imm ? (inst_i.r.rs == '0) : (inst_i.r.shamt == '0));

    always_comb
    begin
        case (inst_i.i.opcode)
            OP_ORI:   i_op = ALU_OR;
            OP_ANDI:  i_op = ALU_AND;
            OP_XORI:  i_op = ALU_XOR;
            OP_LUI:   i_op = ALU_OR;    // rs | (imm << 16)
            OP_ADDI:  i_op = ALU_ADDI;
            OP_ADDIU: i_op = ALU_ADDIU;
            OP_SLTI:  i_op = ALU_SLT;
            OP_SLTIU: i_op = ALU_SLTU;
            default:  i_op = ALU_NOP;
        endcase
    end

    always_comb
    begin
        if (inst_i.i.opcode == OP_LUI)
            i_imm = {inst_i.i.imm16, {(WORD_W-IMM_W){1'b0}}};
        else if (class_of(i_op) == SEL_LOGIC)
            i_imm = {{(WORD_W-IMM_W){1'b0}}, inst_i.i.imm16};
        else
            i_imm = {{(WORD_W-IMM_W){inst_i.i.imm16[IMM_W-1]}}, inst_i.i.imm16};
    end

    assign ok = is_special ? r_ok : (i_op != ALU_NOP);
    assign op = ok ? (is_special ? r_op : i_op) : ALU_NOP;

    always_comb
    begin
        dec.reg1_addr = inst_i.r.rs;
        dec.reg2_addr = inst_i.r.rt;
        if (is_special)
        begin
            dec.reg1_read = r_ok && !shift_imm;
            dec.reg2_read = r_ok;
            dec.imm       = shift_imm ? word_t'(inst_i.r.shamt) : '0;
            dec.wd        = inst_i.r.rd;
        end
        else
        begin
            dec.reg1_read = ok;
            dec.reg2_read = 1'b0;       // second operand is the immediate
            dec.imm       = i_imm;
            dec.wd        = inst_i.i.rt;
        end
    end

    assign dec.aluop   = op;
    assign dec.alusel  = class_of(op);
    assign dec.wreg    = ok;
    assign dec.inst_ok = ok;

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              we_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  id_pkg::word_t     wdata_i,
    input  id_pkg::reg_addr_t raddr1_i,
    input  id_pkg::reg_addr_t raddr2_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o
);
    import id_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_ok;
    logic  wr_hit1;
    logic  wr_hit2;

    assign wr_ok = we_i && (waddr_i != '0);     // r0 is hardwired

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            regs <= '{default: '0};
        else if (wr_ok)
            regs[waddr_i] <= wdata_i;
    end

    // same-cycle write bypasses the array
    assign wr_hit1  = wr_ok && (waddr_i == raddr1_i);
    assign wr_hit2  = wr_ok && (waddr_i == raddr2_i);
    assign rdata1_o = wr_hit1 ? wdata_i : regs[raddr1_i];
    assign rdata2_o = wr_hit2 ? wdata_i : regs[raddr2_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and
        ((raddr2_i == '0) |-> (rdata2_o == '0)));

endmodule

/* operand_mux.sv */
`timescale 1ns/10ps

module operand_mux (
    dec_if.sel            sel,
    fwd_if.snk            fwd,
    input  id_pkg::word_t rdata1_i,
    input  id_pkg::word_t rdata2_i,
    output id_pkg::word_t reg1_o,
    output id_pkg::word_t reg2_o
);
    import id_pkg::*;

    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;

    // r0 never forwards
    function automatic logic hit(input logic wreg, input reg_addr_t wd, input reg_addr_t addr);
        return wreg && (wd == addr) && (addr != '0);
    endfunction

    assign ex_hit1  = hit(fwd.ex_wreg, fwd.ex_wd, sel.reg1_addr);
    assign ex_hit2  = hit(fwd.ex_wreg, fwd.ex_wd, sel.reg2_addr);
    assign mem_hit1 = hit(fwd.mem_wreg, fwd.mem_wd, sel.reg1_addr);
    assign mem_hit2 = hit(fwd.mem_wreg, fwd.mem_wd, sel.reg2_addr);

    // youngest result first
    assign reg1_o = !sel.reg1_read ? sel.imm       :
                    ex_hit1        ? fwd.ex_wdata  :
                    mem_hit1       ? fwd.mem_wdata : rdata1_i;
    assign reg2_o = !sel.reg2_read ? sel.imm       :
                    ex_hit2        ? fwd.ex_wdata  :
                    mem_hit2       ? fwd.mem_wdata : rdata2_i;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/10ps

module id_ex_reg (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              inst_valid_i,
    dec_if.pipe               dec,
    input  id_pkg::word_t     reg1_i,
    input  id_pkg::word_t     reg2_i,
    output logic              valid_o,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::alusel_e   alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              inst_err_o
);
    import id_pkg::*;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            valid_o    <= 1'b0;
            aluop_o    <= ALU_NOP;
            alusel_o   <= SEL_NOP;
            wreg_o     <= 1'b0;
            inst_err_o <= 1'b0;
        end
        else
        begin
            valid_o    <= inst_valid_i;
            aluop_o    <= inst_valid_i ? dec.aluop : ALU_NOP;   // bubble on no strobe
            alusel_o   <= inst_valid_i ? dec.alusel : SEL_NOP;
            wreg_o     <= inst_valid_i && dec.wreg;
            inst_err_o <= inst_valid_i && !dec.inst_ok;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inst_valid_i)
        begin
            reg1_o <= reg1_i;
            reg2_o <= reg2_i;
            wd_o   <= dec.wd;
        end
    end

    a_err_no_wreg: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_err_o |-> !wreg_o);

endmodule

/* id_top.sv */
`timescale 1ns/10ps

module id_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              inst_valid_i,
    input  id_pkg::word_t     inst_i,
    input  logic              wb_we_i,
    input  id_pkg::reg_addr_t wb_waddr_i,
    input  id_pkg::word_t     wb_wdata_i,
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    output logic              valid_o,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::alusel_e   alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              inst_err_o
);
    import id_pkg::*;

    word_t rdata1;
    word_t rdata2;
    word_t op1;     // operands before the pipeline register
    word_t op2;

    dec_if dec_bus ();
    fwd_if fwd_bus ();

    assign fwd_bus.ex_wreg   = ex_wreg_i;
    assign fwd_bus.ex_wd     = ex_wd_i;
    assign fwd_bus.ex_wdata  = ex_wdata_i;
    assign fwd_bus.mem_wreg  = mem_wreg_i;
    assign fwd_bus.mem_wd    = mem_wd_i;
    assign fwd_bus.mem_wdata = mem_wdata_i;

    inst_decoder inst_decoder_inst (
        .inst_i (inst_i),
        .dec    (dec_bus.dec)
    );

    regfile regfile_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .raddr1_i (dec_bus.reg1_addr),
        .raddr2_i (dec_bus.reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_mux operand_mux_inst (
        .sel      (dec_bus.sel),
        .fwd      (fwd_bus.snk),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .reg1_o   (op1),
        .reg2_o   (op2)
    );

    id_ex_reg id_ex_reg_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .dec          (dec_bus.pipe),
        .reg1_i       (op1),
        .reg2_i       (op2),
        .valid_o      (valid_o),
        .aluop_o      (aluop_o),
        .alusel_o     (alusel_o),
        .reg1_o       (reg1_o),
        .reg2_o       (reg2_o),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .inst_err_o   (inst_err_o)
    );

endmodule

/* tb_id_top.sv */
`timescale 1ns/10ps

module tb_id_top;
    import id_pkg::*;

    localparam int TIMEOUT_CYC = 2000;

    logic      clk;
    logic      arst_n_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      wb_we_i;
    reg_addr_t wb_waddr_i;
    word_t     wb_wdata_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      valid_o;
    aluop_e    aluop_o;
    alusel_e   alusel_o;
    word_t     reg1_o;
    word_t     reg2_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    logic      inst_err_o;

    word_t shadow [NUM_REGS];   // reference register values
    int    val_errs;
    int    proto_errs;
    int    cycles;

    id_top id_top_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYC)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            val_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            val_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_aluop(input string name, input aluop_e got, input aluop_e exp);
        if (got !== exp)
        begin
            val_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_alusel(input string name, input alusel_e got, input alusel_e exp);
        if (got !== exp)
        begin
            val_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            val_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] shamt,
                                     input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t i_inst(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected operand by priority of ex, mem, write-back and array
    function automatic word_t opnd(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (ex_wreg_i && ex_wd_i == addr)
            return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == addr)
            return mem_wdata_i;
        if (wb_we_i && wb_waddr_i == addr)
            return wb_wdata_i;
        return shadow[addr];
    endfunction

    function automatic aluop_e op_of(input logic [5:0] fn);
        case (fn)
            FN_OR:   return ALU_OR;
            FN_AND:  return ALU_AND;
            FN_XOR:  return ALU_XOR;
            FN_NOR:  return ALU_NOR;
            FN_ADD:  return ALU_ADD;
            FN_ADDU: return ALU_ADDU;
            FN_SUB:  return ALU_SUB;
            FN_SUBU: return ALU_SUBU;
            FN_SLT:  return ALU_SLT;
            default: return ALU_SLTU;
        endcase
    endfunction

    function automatic alusel_e sel_of(input aluop_e op);
        if (op == ALU_OR || op == ALU_AND || op == ALU_XOR || op == ALU_NOR)
            return SEL_LOGIC;
        return SEL_ARITH;
    endfunction

    task automatic wb_write(input reg_addr_t addr, input word_t data);
        wb_we_i    = 1'b1;
        wb_waddr_i = addr;
        wb_wdata_i = data;
        @(posedge clk);
        if (addr != '0)
            shadow[addr] = data;
        #1;
        wb_we_i = 1'b0;
    endtask

    // strobe one instruction and check the result one cycle later
    task automatic issue(input word_t inst, input aluop_e op, input alusel_e sel,
                         input word_t r1, input word_t r2, input reg_addr_t wd,
                         input logic err);
        inst_i       = inst;
        inst_valid_i = 1'b1;
        @(posedge clk);
        if (wb_we_i && wb_waddr_i != '0)
            shadow[wb_waddr_i] = wb_wdata_i;
        #1;
        inst_valid_i = 1'b0;
        wb_we_i      = 1'b0;
        ex_wreg_i    = 1'b0;
        mem_wreg_i   = 1'b0;
        if (valid_o !== 1'b1)
        begin
            proto_errs++;
            $display("valid_o did not rise one cycle after instruction %h", inst);
        end
        check_aluop("aluop_o", aluop_o, op);
        check_alusel("alusel_o", alusel_o, sel);
        check_bit("wreg_o", wreg_o, !err);
        check_bit("inst_err_o", inst_err_o, err);
        if (!err)
        begin
            check_word("reg1_o", reg1_o, r1);
            check_word("reg2_o", reg2_o, r2);
            check_addr("wd_o", wd_o, wd);
        end
    endtask

    task automatic test_rtype();
        for (int i = 1; i <= 8; i++)
            wb_write(reg_addr_t'(i), $urandom());
        issue(r_inst(1, 2, 9, 0, FN_ADD), ALU_ADD, SEL_ARITH, opnd(1), opnd(2), 9, 1'b0);
        issue(r_inst(3, 4, 10, 0, FN_SUB), ALU_SUB, SEL_ARITH, opnd(3), opnd(4), 10, 1'b0);
        issue(r_inst(5, 6, 11, 0, FN_SLT), ALU_SLT, SEL_ARITH, opnd(5), opnd(6), 11, 1'b0);
        issue(r_inst(7, 8, 12, 0, FN_AND), ALU_AND, SEL_LOGIC, opnd(7), opnd(8), 12, 1'b0);
        issue(r_inst(2, 7, 13, 0, FN_OR), ALU_OR, SEL_LOGIC, opnd(2), opnd(7), 13, 1'b0);
        issue(r_inst(4, 1, 14, 0, FN_NOR), ALU_NOR, SEL_LOGIC, opnd(4), opnd(1), 14, 1'b0);
        issue(r_inst(6, 3, 15, 0, FN_XOR), ALU_XOR, SEL_LOGIC, opnd(6), opnd(3), 15, 1'b0);
    endtask

    task automatic test_itype();
        issue(i_inst(OP_ORI, 1, 16, 16'h8a5c), ALU_OR, SEL_LOGIC, opnd(1), 32'h0000_8a5c,
              16, 1'b0);
        issue(i_inst(OP_ANDI, 2, 17, 16'hf00f), ALU_AND, SEL_LOGIC, opnd(2), 32'h0000_f00f,
              17, 1'b0);
        issue(i_inst(OP_XORI, 3, 18, 16'hffff), ALU_XOR, SEL_LOGIC, opnd(3), 32'h0000_ffff,
              18, 1'b0);
        issue(i_inst(OP_ADDI, 4, 19, 16'hfff0), ALU_ADDI, SEL_ARITH, opnd(4), 32'hffff_fff0,
              19, 1'b0);
        issue(i_inst(OP_ADDIU, 5, 20, 16'h8000), ALU_ADDIU, SEL_ARITH, opnd(5),
              32'hffff_8000, 20, 1'b0);
        issue(i_inst(OP_SLTI, 6, 21, 16'hc001), ALU_SLT, SEL_ARITH, opnd(6), 32'hffff_c001,
              21, 1'b0);
        issue(i_inst(OP_SLTIU, 7, 22, 16'hfffe), ALU_SLTU, SEL_ARITH, opnd(7),
              32'hffff_fffe, 22, 1'b0);
        issue(i_inst(OP_LUI, 0, 23, 16'h1234), ALU_OR, SEL_LOGIC, 32'h0, 32'h1234_0000,
              23, 1'b0);
    endtask

    task automatic test_shift();
        issue(r_inst(0, 3, 24, 5, FN_SLL), ALU_SLL, SEL_SHIFT, 32'd5, opnd(3), 24, 1'b0);
        issue(r_inst(0, 4, 25, 31, FN_SRL), ALU_SRL, SEL_SHIFT, 32'd31, opnd(4), 25, 1'b0);
        issue(r_inst(0, 5, 26, 1, FN_SRA), ALU_SRA, SEL_SHIFT, 32'd1, opnd(5), 26, 1'b0);
        issue(r_inst(4, 5, 27, 0, FN_SLLV), ALU_SLL, SEL_SHIFT, opnd(4), opnd(5), 27, 1'b0);
    endtask

    task automatic test_forward();
        ex_wreg_i   = 1'b1;     // both stages hit rs
        ex_wd_i     = 1;
        ex_wdata_i  = 32'hdead_0001;
        mem_wreg_i  = 1'b1;
        mem_wd_i    = 1;
        mem_wdata_i = 32'hbeef_0001;
        issue(r_inst(1, 2, 9, 0, FN_OR), ALU_OR, SEL_LOGIC, 32'hdead_0001, opnd(2), 9, 1'b0);
        ex_wreg_i   = 1'b1;
        ex_wd_i     = 7;
        mem_wreg_i  = 1'b1;
        mem_wd_i    = 2;
        mem_wdata_i = 32'h0bad_cafe;
        issue(r_inst(3, 2, 10, 0, FN_ADD), ALU_ADD, SEL_ARITH, opnd(3), 32'h0bad_cafe,
              10, 1'b0);
        ex_wreg_i  = 1'b1;      // r0 forwards must not apply
        ex_wd_i    = 0;
        mem_wreg_i = 1'b1;
        mem_wd_i   = 0;
        issue(r_inst(0, 0, 11, 0, FN_XOR), ALU_XOR, SEL_LOGIC, 32'h0, 32'h0, 11, 1'b0);
        wb_we_i    = 1'b1;
        wb_waddr_i = 3;
        wb_wdata_i = 32'h5a5a_0f0f;
        issue(r_inst(3, 4, 12, 0, FN_AND), ALU_AND, SEL_LOGIC, 32'h5a5a_0f0f, opnd(4),
              12, 1'b0);
    endtask

    task automatic test_invalid();
        issue(i_inst(6'b111111, 1, 2, 16'h1234), ALU_NOP, SEL_NOP, '0, '0, '0, 1'b1);
        issue(r_inst(1, 2, 0, 0, 6'b011000), ALU_NOP, SEL_NOP, '0, '0, '0, 1'b1);  // mult
        @(posedge clk);
        #1;
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("wreg_o", wreg_o, 1'b0);
    endtask

    task automatic test_random();
        logic [5:0] fns [10];
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        aluop_e     op;
        fns = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                FN_SLT, FN_SLTU};
        for (int n = 0; n < 100; n++)
        begin
            fn          = fns[$urandom_range(0, 9)];
            rs          = $urandom_range(0, 7);     // narrow range for frequent hits
            rt          = $urandom_range(0, 7);
            rd          = $urandom_range(0, 31);
            ex_wreg_i   = $urandom_range(0, 1);
            ex_wd_i     = $urandom_range(0, 7);
            ex_wdata_i  = $urandom();
            mem_wreg_i  = $urandom_range(0, 1);
            mem_wd_i    = $urandom_range(0, 7);
            mem_wdata_i = $urandom();
            wb_we_i     = $urandom_range(0, 1);
            wb_waddr_i  = $urandom_range(0, 7);
            wb_wdata_i  = $urandom();
            op          = op_of(fn);
            issue(r_inst(rs, rt, rd, 0, fn), op, sel_of(op), opnd(rs), opnd(rt), rd, 1'b0);
        end
    endtask

    initial
    begin
        void'($urandom(77112));
        val_errs     = 0;
        proto_errs   = 0;
        cycles       = 0;
        shadow       = '{default: '0};
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_we_i      = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;
        ex_wreg_i    = 1'b0;
        ex_wd_i      = '0;
        ex_wdata_i   = '0;
        mem_wreg_i   = 1'b0;
        mem_wd_i     = '0;
        mem_wdata_i  = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("wreg_o", wreg_o, 1'b0);
        check_bit("inst_err_o", inst_err_o, 1'b0);
        check_aluop("aluop_o", aluop_o, ALU_NOP);
        check_alusel("alusel_o", alusel_o, SEL_NOP);
        test_rtype();
        test_itype();
        test_shift();
        test_forward();
        test_invalid();
        test_random();
        $display("value errors: %0d, protocol errors: %0d", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim.f */
id_pkg.sv
id_if.sv
inst_decoder.sv
regfile.sv
operand_mux.sv
id_ex_reg.sv
id_top.sv
tb_id_top.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - id_pkg.sv
  - id_if.sv
  - inst_decoder.sv
  - regfile.sv
  - operand_mux.sv
  - id_ex_reg.sv
  - id_top.sv
  - target: simulation
    files:
      - tb_id_top.sv
